// ==== files.f ====
+incdir+hw
hw/cache_link_pkg.sv
hw/request_fifo.sv
hw/link_to_cache.sv
hw/cache_store_pipe.sv
hw/cache_link_top.sv
tests/clock_gen.sv
tests/cache_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cache_link_tb -f files.f
out=$(./obj_dir/Vcache_link_tb 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1

// ==== tests/cache_link_tb.sv ====
// self-checking testbench that applies a table of requests to cache_link_top against a reference memory
`timescale 1ns/100ps
`include "cache_link_params.svh"

module cache_link_tb;

  typedef struct packed {
    cache_link_pkg::req_pkt_s req;
    logic [2:0] ret_count;
    cache_link_pkg::return_pkt_s [`CL_IFETCH_WORDS-1:0] ret;
    logic route_chk;
    logic route_val;
  } test_entry_s;

  typedef struct packed {
    cache_link_pkg::return_pkt_s pkt;
    logic route_chk;
    logic route_val;
  } exp_return_s;

  localparam int sweep_cycles_lp = `CL_SETS * `CL_WAYS + 6;
  localparam int blk_w_lp = $clog2(`CL_BLOCK_WORDS);
  localparam int tag_w_lp = $clog2(`CL_SETS * `CL_WAYS);
  localparam cache_link_pkg::link_op_e st_op_lp = cache_link_pkg::e_remote_store;
  localparam cache_link_pkg::link_op_e sw_op_lp = cache_link_pkg::e_remote_sw;
  localparam cache_link_pkg::link_op_e ld_op_lp = cache_link_pkg::e_remote_load;
  localparam cache_link_pkg::link_op_e add_op_lp = cache_link_pkg::e_remote_amoadd;
  localparam cache_link_pkg::link_op_e swap_op_lp = cache_link_pkg::e_remote_amoswap;

  logic clk, reset;
  cache_link_pkg::req_pkt_s req_pkt;
  logic req_v, req_ready;
  cache_link_pkg::return_pkt_s return_pkt;
  logic return_v, return_ready, route_east;

  test_entry_s tests_q[$];
  exp_return_s exp_q[$];
  exp_return_s next_exp;
  cache_link_pkg::data_t ref_mem [2 ** (`CL_LINK_ADDR_WIDTH - 1)];
  cache_link_pkg::data_t ref_tag [`CL_SETS * `CL_WAYS];
  logic route_ref;
  logic tests_built = 1'b0;
  int returns_seen = 0;
  int total_returns;

  clock_gen clocks (.clk_o(clk), .reset_o(reset));

  cache_link_top UUT (
    .clk_i(clk), .reset_i(reset),
    .req_pkt_i(req_pkt), .req_v_i(req_v), .req_ready_o(req_ready),
    .return_pkt_o(return_pkt), .return_v_o(return_v), .return_ready_i(return_ready),
    .route_east_o(route_east)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1);
  endtask

  function automatic string format_return(input cache_link_pkg::return_pkt_s p);
    return $sformatf("type %0d data %h reg %0d y %0d x %0d",
                     p.pkt_type, p.data, p.reg_id, p.y_cord, p.x_cord);
  endfunction

  task automatic check_return(input cache_link_pkg::return_pkt_s expected,
                              input cache_link_pkg::return_pkt_s actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error at %0t: return_pkt_o expected %s, got %s", $time,
                          format_return(expected), format_return(actual)));
    end
  endtask

  task automatic check_route(input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error at %0t: route_east_o expected %b, got %b", $time,
                          expected, actual));
    end
  endtask

  function automatic cache_link_pkg::load_info_s make_load_info(input logic fetch,
      input logic is_byte, input logic is_half, input logic is_unsigned, input logic [1:0] part);
    return '{icache_fetch: fetch, is_byte_op: is_byte, is_hex_op: is_half,
             is_unsigned_op: is_unsigned, part_sel: part};
  endfunction

  // reference model that works out the returns of one request and updates the memories
  task automatic add_test(input cache_link_pkg::link_op_e op,
                          input cache_link_pkg::link_addr_t addr,
                          input cache_link_pkg::data_t payload,
                          input cache_link_pkg::mask_t mask,
                          input cache_link_pkg::load_info_s info);
    test_entry_s e;
    cache_link_pkg::return_pkt_s rp;
    cache_link_pkg::data_t old;
    logic [7:0] b;
    logic [15:0] h;
    logic is_store;
    int tidx, widx, base;
    e = '0;
    e.req.op = op;
    e.req.addr = addr;
    e.req.payload = payload;
    e.req.mask = mask;
    e.req.load_info = info;
    e.req.reg_id = cache_link_pkg::reg_id_t'(tests_q.size() + 3);
    e.req.src_x_cord = cache_link_pkg::x_cord_t'(tests_q.size() * 5);
    e.req.src_y_cord = cache_link_pkg::y_cord_t'(tests_q.size() * 3 + 1);
    rp = '0;
    rp.reg_id = e.req.reg_id;
    rp.x_cord = e.req.src_x_cord;
    rp.y_cord = e.req.src_y_cord;
    is_store = (op == st_op_lp) || (op == sw_op_lp);
    rp.pkt_type = is_store ? cache_link_pkg::e_return_credit : cache_link_pkg::e_return_int_wb;
    tidx = int'(addr[blk_w_lp +: tag_w_lp]);
    widx = int'(addr[`CL_LINK_ADDR_WIDTH-2:0]);
    old = ref_mem[widx];
    e.ret_count = 1;
    if (addr[`CL_LINK_ADDR_WIDTH-1 -: 2] == 2'b11) begin
      // config word reads back the tag entry it aliases
      rp.data = ref_tag[tidx];
      e.route_chk = 1'b1;
      e.route_val = payload[0];
      route_ref = payload[0];
    end else if (addr[`CL_LINK_ADDR_WIDTH-1]) begin
      if (is_store) begin
        ref_tag[tidx] = payload;
      end else if (op == ld_op_lp) begin
        rp.data = ref_tag[tidx];
      end
    end else begin
      case (op)
        st_op_lp: begin
          for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
              ref_mem[widx][8*i +: 8] = payload[8*i +: 8];
            end
          end
        end
        sw_op_lp: ref_mem[widx] = payload;
        add_op_lp: begin
          rp.data = old;
          ref_mem[widx] = old + payload;
        end
        swap_op_lp: begin
          rp.data = old;
          ref_mem[widx] = payload;
        end
        default: begin
          if (info.icache_fetch) begin
            rp.pkt_type = cache_link_pkg::e_return_ifetch;
            e.ret_count = `CL_IFETCH_WORDS;
            base = widx - (widx % `CL_IFETCH_WORDS);
            for (int w = 0; w < `CL_IFETCH_WORDS; w++) begin
              rp.data = ref_mem[base + w];
              e.ret[w] = rp;
            end
          end else if (info.is_byte_op) begin
            b = old[8*info.part_sel +: 8];
            rp.data = info.is_unsigned_op ? {24'b0, b} : {{24{b[7]}}, b};
          end else if (info.is_hex_op) begin
            h = 16'(old >> (8 * info.part_sel));
            rp.data = info.is_unsigned_op ? {16'b0, h} : {{16{h[15]}}, h};
          end else begin
            rp.data = old;
          end
        end
      endcase
    end
    if (e.ret_count == 1) begin
      e.ret[0] = rp;
    end
    tests_q.push_back(e);
  endtask

  task automatic build_tests();
    cache_link_pkg::load_info_s lw;
    lw = make_load_info(1'b0, 1'b0, 1'b0, 1'b0, 2'd0);
    // tag entries start cleared by the sweep
    for (int i = 0; i < `CL_SETS * `CL_WAYS; i++) begin
      ref_tag[i] = '0;
    end
    route_ref = 1'b0;
    add_test(ld_op_lp, 10'h200, '0, '0, lw);
    add_test(ld_op_lp, 10'h214, '0, '0, lw);
    add_test(ld_op_lp, 10'h23c, '0, '0, lw);
    add_test(sw_op_lp, 10'h214, 32'h5a5a_0f0f, '0, lw);
    add_test(ld_op_lp, 10'h214, '0, '0, lw);
    add_test(swap_op_lp, 10'h214, '0, '0, lw);
    add_test(ld_op_lp, 10'h214, '0, '0, lw);
    // masked and full-word stores
    add_test(sw_op_lp, 10'h010, 32'h1122_3344, '0, lw);
    add_test(st_op_lp, 10'h010, 32'haabb_ccdd, 4'b0101, lw);
    add_test(ld_op_lp, 10'h010, '0, '0, lw);
    add_test(sw_op_lp, 10'h011, 32'hcafe_0000, '0, lw);
    add_test(st_op_lp, 10'h011, 32'h1234_5678, 4'b1010, lw);
    add_test(ld_op_lp, 10'h011, '0, '0, lw);
    // every byte and half position in signed and unsigned form
    add_test(sw_op_lp, 10'h020, 32'h80f1_7f01, '0, lw);
    for (int p = 0; p < 4; p++) begin
      for (int u = 0; u < 2; u++) begin
        add_test(ld_op_lp, 10'h020, '0, '0, make_load_info(1'b0, 1'b1, 1'b0, u[0], p[1:0]));
      end
    end
    for (int p = 0; p < 4; p += 2) begin
      for (int u = 0; u < 2; u++) begin
        add_test(ld_op_lp, 10'h020, '0, '0, make_load_info(1'b0, 1'b0, 1'b1, u[0], p[1:0]));
      end
    end
    add_test(sw_op_lp, 10'h030, 32'd100, '0, lw);
    add_test(add_op_lp, 10'h030, 32'd23, '0, lw);
    add_test(ld_op_lp, 10'h030, '0, '0, lw);
    add_test(swap_op_lp, 10'h030, 32'hdead_beef, '0, lw);
    add_test(ld_op_lp, 10'h030, '0, '0, lw);
    // instruction block fetched twice from different words inside it
    for (int w = 0; w < `CL_IFETCH_WORDS; w++) begin
      add_test(sw_op_lp, cache_link_pkg::link_addr_t'(32'h40 + w), 32'h0bad_0000 + w * 32'h101,
               '0, lw);
    end
    add_test(ld_op_lp, 10'h042, '0, '0, make_load_info(1'b1, 1'b0, 1'b0, 1'b0, 2'd0));
    add_test(ld_op_lp, 10'h041, '0, '0, make_load_info(1'b1, 1'b0, 1'b0, 1'b0, 2'd0));
    // config writes kept apart so each route level is seen on its own return
    add_test(sw_op_lp, 10'h300, 32'h1, '0, lw);
    add_test(ld_op_lp, 10'h010, '0, '0, lw);
    add_test(sw_op_lp, 10'h304, 32'h0, '0, lw);
  endtask

  task automatic send_request(input cache_link_pkg::req_pkt_s pkt);
    req_pkt = pkt;
    req_v = 1'b1;
    @(negedge clk);
    while (req_ready !== 1'b1) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_v = 1'b0;
  endtask

  // random return back-pressure
  initial begin
    void'($urandom(32'hbfec_b4c5));
    return_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1 return_ready = ($urandom % 4) != 0;
    end
  end

  always @(negedge clk) begin
    if (!reset && return_v && return_ready) begin
      if (exp_q.size() == 0) begin
        abort_run("A return packet arrived that no request asked for");
      end else begin
        next_exp = exp_q.pop_front();
        check_return(next_exp.pkt, return_pkt);
        if (next_exp.route_chk) begin
          check_route(next_exp.route_val, route_east);
        end
        returns_seen++;
      end
    end
  end

  initial begin
    wait (tests_built);
    repeat (tests_q.size() * 200 + sweep_cycles_lp) @(posedge clk);
    abort_run("Timeout: not every expected return packet arrived in time");
  end

  initial begin
    req_v = 1'b0;
    req_pkt = '0;
    build_tests();
    foreach (tests_q[i]) begin
      for (int w = 0; w < tests_q[i].ret_count; w++) begin
        exp_q.push_back('{pkt: tests_q[i].ret[w], route_chk: tests_q[i].route_chk,
                          route_val: tests_q[i].route_val});
      end
    end
    total_returns = exp_q.size();
    tests_built = 1'b1;
    while (reset !== 1'b0) begin
      @(posedge clk);
    end
    #1;
    foreach (tests_q[i]) begin
      send_request(tests_q[i].req);
    end
    while (returns_seen < total_returns) begin
      @(posedge clk);
    end
    // quiet period to catch duplicated returns
    repeat (20) @(posedge clk);
    check_route(route_ref, route_east);
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== tests/clock_gen.sv ====
// testbench clock and reset source, 20 ns period with reset held over the first 3 rising edges
`timescale 1ns/100ps

module clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule

// ==== hw/cache_link_top.sv ====
// top level of the cache-side network adapter: request FIFO, adapter and cache pipeline
`timescale 1ns/100ps

module cache_link_top (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  cache_link_pkg::req_pkt_s     req_pkt_i,
  input  logic                         req_v_i,
  output logic                         req_ready_o,
  output cache_link_pkg::return_pkt_s  return_pkt_o,
  output logic                         return_v_o,
  input  logic                         return_ready_i,
  output logic                         route_east_o
);

  cache_link_pkg::req_pkt_s fifo_pkt;
  logic fifo_v, fifo_yumi;
  cache_link_pkg::cache_pkt_s cache_pkt;
  logic cache_v, cache_ready;
  cache_link_pkg::data_t result_data;
  logic result_v, result_yumi;
  logic tv_we;

  request_fifo fifo (
    .clk_i, .reset_i, .req_pkt_i, .req_v_i, .req_ready_o,
    .deq_pkt_o(fifo_pkt), .deq_v_o(fifo_v), .deq_yumi_i(fifo_yumi)
  );

  link_to_cache adapter (
    .clk_i, .reset_i,
    .fifo_pkt_i(fifo_pkt), .fifo_v_i(fifo_v), .fifo_yumi_o(fifo_yumi),
    .cache_pkt_o(cache_pkt), .cache_v_o(cache_v), .cache_ready_i(cache_ready),
    .result_data_i(result_data), .result_v_i(result_v), .result_yumi_o(result_yumi),
    .tv_we_i(tv_we),
    .return_pkt_o, .return_v_o, .return_ready_i, .route_east_o
  );

  cache_store_pipe cache (
    .clk_i, .reset_i,
    .cache_pkt_i(cache_pkt), .cache_v_i(cache_v), .cache_ready_o(cache_ready),
    .data_o(result_data), .v_o(result_v), .yumi_i(result_yumi), .tv_we_o(tv_we)
  );

endmodule

// ==== hw/cache_store_pipe.sv ====
// two-stage always-hit cache model with data and tag arrays, sits behind the link adapter
`timescale 1ns/100ps
`include "cache_link_params.svh"

module cache_store_pipe (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  cache_link_pkg::cache_pkt_s  cache_pkt_i,
  input  logic                        cache_v_i,
  output logic                        cache_ready_o,
  output cache_link_pkg::data_t       data_o,
  output logic                        v_o,
  input  logic                        yumi_i,
  output logic                        tv_we_o
);

  localparam int data_els_lp = 2 ** (`CL_LINK_ADDR_WIDTH - 1);
  localparam int tag_els_lp = `CL_SETS * `CL_WAYS;
  localparam int tag_idx_w_lp = $clog2(tag_els_lp);
  localparam int block_off_w_lp = $clog2(`CL_BLOCK_WORDS) + 2;
  localparam int dw_lp = `CL_DATA_WIDTH;

  cache_link_pkg::data_t data_mem [data_els_lp];
  cache_link_pkg::data_t tag_mem [tag_els_lp];

  logic tl_v_r, tv_v_r;
  cache_link_pkg::cache_pkt_s tl_pkt_r;
  cache_link_pkg::data_t tv_data_r;

  logic [`CL_CACHE_ADDR_WIDTH-3:0] word_idx;
  logic [tag_idx_w_lp-1:0] tag_idx;
  logic is_tag_op;
  cache_link_pkg::data_t rdata, wdata, result;
  logic data_we, tag_we;
  logic [7:0] byte_sel;
  logic [15:0] half_sel;

  assign word_idx = tl_pkt_r.addr[`CL_CACHE_ADDR_WIDTH-1:2];
  assign tag_idx = tl_pkt_r.addr[block_off_w_lp +: tag_idx_w_lp];
  assign is_tag_op = tl_pkt_r.opcode inside {cache_link_pkg::e_op_tagst,
                                             cache_link_pkg::e_op_tagla,
                                             cache_link_pkg::e_op_tagfl};
  assign rdata = is_tag_op ? tag_mem[tag_idx] : data_mem[word_idx];
  assign byte_sel = rdata[{tl_pkt_r.addr[1:0], 3'b000} +: 8];
  assign half_sel = tl_pkt_r.addr[1] ? rdata[31:16] : rdata[15:0];

  assign tv_we_o = tl_v_r & (~tv_v_r | yumi_i);
  assign cache_ready_o = ~tl_v_r | tv_we_o;
  assign v_o = tv_v_r;
  assign data_o = tv_data_r;

  // result and write-back value for the entry leaving lookup
  always_comb begin
    wdata = rdata;
    result = '0;
    data_we = 1'b0;
    tag_we = 1'b0;
    case (tl_pkt_r.opcode)
      cache_link_pkg::e_op_sm: begin
        data_we = 1'b1;
        for (int i = 0; i < 4; i++) begin
          if (tl_pkt_r.mask[i]) begin
            wdata[8*i +: 8] = tl_pkt_r.data[8*i +: 8];
          end
        end
      end
      cache_link_pkg::e_op_lw: result = rdata;
      cache_link_pkg::e_op_lh: result = {{(dw_lp-16){half_sel[15]}}, half_sel};
      cache_link_pkg::e_op_lhu: result = {{(dw_lp-16){1'b0}}, half_sel};
      cache_link_pkg::e_op_lb: result = {{(dw_lp-8){byte_sel[7]}}, byte_sel};
      cache_link_pkg::e_op_lbu: result = {{(dw_lp-8){1'b0}}, byte_sel};
      cache_link_pkg::e_op_amoadd: begin
        data_we = 1'b1;
        wdata = rdata + tl_pkt_r.data;
        result = rdata;
      end
      cache_link_pkg::e_op_amoswap: begin
        data_we = 1'b1;
        wdata = tl_pkt_r.data;
        result = rdata;
      end
      cache_link_pkg::e_op_tagst: tag_we = 1'b1;
      cache_link_pkg::e_op_tagla: result = rdata;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r <= 1'b0;
      tv_v_r <= 1'b0;
    end else begin
      if (cache_ready_o) begin
        tl_v_r <= cache_v_i;
      end
      tv_v_r <= tv_we_o | (tv_v_r & ~yumi_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_v_i & cache_ready_o) begin
      tl_pkt_r <= cache_pkt_i;
    end
    if (tv_we_o) begin
      tv_data_r <= result;
      if (data_we) begin
        data_mem[word_idx] <= wdata;
      end
      if (tag_we) begin
        tag_mem[tag_idx] <= tl_pkt_r.data;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);

endmodule

// ==== hw/link_to_cache.sv ====
// adapter that maps queued link requests onto the cache pipeline and builds the return packets
`timescale 1ns/100ps
`include "cache_link_params.svh"

module link_to_cache (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  cache_link_pkg::req_pkt_s     fifo_pkt_i,
  input  logic                         fifo_v_i,
  output logic                         fifo_yumi_o,
  output cache_link_pkg::cache_pkt_s   cache_pkt_o,
  output logic                         cache_v_o,
  input  logic                         cache_ready_i,
  input  cache_link_pkg::data_t        result_data_i,
  input  logic                         result_v_i,
  output logic                         result_yumi_o,
  input  logic                         tv_we_i,
  output cache_link_pkg::return_pkt_s  return_pkt_o,
  output logic                         return_v_o,
  input  logic                         return_ready_i,
  output logic                         route_east_o
);

  localparam int la_w_lp = `CL_LINK_ADDR_WIDTH;
  localparam int fetch_w_lp = $clog2(`CL_IFETCH_WORDS);
  localparam int tag_entries_lp = `CL_SETS * `CL_WAYS;
  localparam int tag_idx_w_lp = $clog2(tag_entries_lp);
  localparam int block_off_w_lp = $clog2(`CL_BLOCK_WORDS) + 2;
  localparam int tag_pad_w_lp = `CL_CACHE_ADDR_WIDTH - tag_idx_w_lp - block_off_w_lp;

  typedef enum logic [1:0] {
    e_reset,
    e_clear_tag,
    e_ready,
    e_fetch
  } state_e;

  state_e state_r, state_n;
  logic [tag_idx_w_lp:0] tagst_sent_r, tagst_sent_n;
  logic [tag_idx_w_lp:0] tagst_recv_r, tagst_recv_n;
  logic sweep_done_r, sweep_done_n;
  logic route_r, route_n;
  logic [fetch_w_lp-1:0] fetch_count_r;
  logic fetch_count_up;
  logic is_fetch;
  logic last_word;
  cache_link_pkg::load_info_s load_info;
  cache_link_pkg::return_type_e req_type;
  cache_link_pkg::return_info_s tl_info_r, tv_info_r;

  assign load_info = fifo_pkt_i.load_info;
  assign is_fetch = (fifo_pkt_i.op == cache_link_pkg::e_remote_load) & load_info.icache_fetch;
  assign last_word = (fetch_count_r == fetch_w_lp'(`CL_IFETCH_WORDS - 1));
  assign route_east_o = route_r;

  always_comb begin
    case (fifo_pkt_i.op)
      cache_link_pkg::e_remote_store, cache_link_pkg::e_remote_sw: begin
        req_type = cache_link_pkg::e_return_credit;
      end
      cache_link_pkg::e_remote_load: begin
        req_type = load_info.icache_fetch ? cache_link_pkg::e_return_ifetch
                                          : cache_link_pkg::e_return_int_wb;
      end
      default: req_type = cache_link_pkg::e_return_int_wb;
    endcase
  end

  always_comb begin
    cache_pkt_o.opcode = cache_link_pkg::e_op_tagst;
    cache_pkt_o.addr = '0;
    cache_pkt_o.data = '0;
    cache_pkt_o.mask = '0;
    cache_v_o = 1'b0;
    fifo_yumi_o = 1'b0;
    result_yumi_o = 1'b0;
    return_v_o = 1'b0;
    fetch_count_up = 1'b0;
    state_n = state_r;
    tagst_sent_n = tagst_sent_r;
    tagst_recv_n = tagst_recv_r;
    sweep_done_n = sweep_done_r;
    route_n = route_r;

    case (state_r)
      e_reset: state_n = e_clear_tag;

      e_clear_tag: begin
        cache_v_o = (tagst_sent_r != tag_entries_lp);
        cache_pkt_o.addr = {{tag_pad_w_lp{1'b0}}, tagst_sent_r[tag_idx_w_lp-1:0],
                            {block_off_w_lp{1'b0}}};
        if (cache_v_o & cache_ready_i) begin
          tagst_sent_n = tagst_sent_r + 1'b1;
        end
        // sweep results are swallowed
        result_yumi_o = result_v_i;
        if (result_v_i) begin
          tagst_recv_n = tagst_recv_r + 1'b1;
        end
        if ((tagst_sent_r == tag_entries_lp) && (tagst_recv_r == tag_entries_lp)) begin
          state_n = e_ready;
          sweep_done_n = 1'b1;
        end
      end

      e_ready: begin
        cache_v_o = fifo_v_i;
        fifo_yumi_o = ~is_fetch & fifo_v_i & cache_ready_i;
        cache_pkt_o.data = fifo_pkt_i.payload;
        cache_pkt_o.mask = (fifo_pkt_i.op == cache_link_pkg::e_remote_sw) ? 4'b1111
                                                                         : fifo_pkt_i.mask;
        cache_pkt_o.addr = {fifo_pkt_i.addr[la_w_lp-2:0], 2'b00};

        if (fifo_pkt_i.addr[la_w_lp-1 -: 2] == 2'b11) begin
          // config word rides through as a tag load no-op
          cache_pkt_o.opcode = cache_link_pkg::e_op_tagla;
          if (fifo_v_i & cache_ready_i) begin
            route_n = fifo_pkt_i.payload[0];
          end
        end else if (fifo_pkt_i.addr[la_w_lp-1]) begin
          case (fifo_pkt_i.op)
            cache_link_pkg::e_remote_store, cache_link_pkg::e_remote_sw:
              cache_pkt_o.opcode = cache_link_pkg::e_op_tagst;
            cache_link_pkg::e_remote_load: cache_pkt_o.opcode = cache_link_pkg::e_op_tagla;
            // atomics to tag space flush
            default: cache_pkt_o.opcode = cache_link_pkg::e_op_tagfl;
          endcase
        end else begin
          case (fifo_pkt_i.op)
            cache_link_pkg::e_remote_amoadd: cache_pkt_o.opcode = cache_link_pkg::e_op_amoadd;
            cache_link_pkg::e_remote_amoswap: cache_pkt_o.opcode = cache_link_pkg::e_op_amoswap;
            cache_link_pkg::e_remote_load: begin
              if (load_info.is_byte_op) begin
                cache_pkt_o.opcode = load_info.is_unsigned_op ? cache_link_pkg::e_op_lbu
                                                              : cache_link_pkg::e_op_lb;
              end else if (load_info.is_hex_op) begin
                cache_pkt_o.opcode = load_info.is_unsigned_op ? cache_link_pkg::e_op_lhu
                                                              : cache_link_pkg::e_op_lh;
              end else begin
                cache_pkt_o.opcode = cache_link_pkg::e_op_lw;
              end
              cache_pkt_o.addr = {fifo_pkt_i.addr[la_w_lp-2:fetch_w_lp],
                                  is_fetch ? fetch_count_r : fifo_pkt_i.addr[fetch_w_lp-1:0],
                                  is_fetch ? 2'b00 : load_info.part_sel};
            end
            default: cache_pkt_o.opcode = cache_link_pkg::e_op_sm;
          endcase
        end

        return_v_o = result_v_i;
        result_yumi_o = result_v_i & return_ready_i;
        fetch_count_up = is_fetch & fifo_v_i & cache_ready_i;
        if (fetch_count_up) begin
          state_n = e_fetch;
        end
      end

      e_fetch: begin
        // request stays at the head until its last word goes out
        cache_v_o = fifo_v_i;
        cache_pkt_o.opcode = cache_link_pkg::e_op_lw;
        cache_pkt_o.addr = {fifo_pkt_i.addr[la_w_lp-2:fetch_w_lp], fetch_count_r, 2'b00};
        fifo_yumi_o = fifo_v_i & cache_ready_i & last_word;
        return_v_o = result_v_i;
        result_yumi_o = result_v_i & return_ready_i;
        fetch_count_up = fifo_v_i & cache_ready_i;
        if (fetch_count_up & last_word) begin
          state_n = e_ready;
        end
      end

      default: state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
      tagst_sent_r <= '0;
      tagst_recv_r <= '0;
      sweep_done_r <= 1'b0;
      route_r <= 1'b0;
      fetch_count_r <= '0;
    end else begin
      state_r <= state_n;
      tagst_sent_r <= tagst_sent_n;
      tagst_recv_r <= tagst_recv_n;
      sweep_done_r <= sweep_done_n;
      route_r <= route_n;
      if (fetch_count_up) begin
        fetch_count_r <= fetch_count_r + 1'b1;
      end
    end
  end

  // tracker mirrors the cache's lookup and result stages once the sweep is over
  always_ff @(posedge clk_i) begin
    if (sweep_done_r) begin
      if (cache_v_o & cache_ready_i) begin
        tl_info_r <= '{pkt_type: req_type, reg_id: fifo_pkt_i.reg_id,
                       y_cord: fifo_pkt_i.src_y_cord, x_cord: fifo_pkt_i.src_x_cord};
      end
      if (tv_we_i) begin
        tv_info_r <= tl_info_r;
      end
    end
  end

  always_comb begin
    return_pkt_o.pkt_type = tv_info_r.pkt_type;
    return_pkt_o.data = result_data_i;
    return_pkt_o.reg_id = tv_info_r.reg_id;
    return_pkt_o.y_cord = tv_info_r.y_cord;
    return_pkt_o.x_cord = tv_info_r.x_cord;
  end

  // every sweep result answers a tag store already sent
  assert property (@(posedge clk_i) disable iff (reset_i)
    ((state_r == e_clear_tag) && result_v_i) |-> (tagst_recv_r < tagst_sent_r));

endmodule

// ==== hw/request_fifo.sv ====
// input FIFO that queues request packets from the mesh link ahead of the adapter
`timescale 1ns/100ps
`include "cache_link_params.svh"

module request_fifo (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  cache_link_pkg::req_pkt_s  req_pkt_i,
  input  logic                      req_v_i,
  output logic                      req_ready_o,
  output cache_link_pkg::req_pkt_s  deq_pkt_o,
  output logic                      deq_v_o,
  input  logic                      deq_yumi_i
);

  localparam int ptr_w_lp = $clog2(`CL_FIFO_ELS);
  localparam int count_w_lp = $clog2(`CL_FIFO_ELS + 1);

  cache_link_pkg::req_pkt_s mem [`CL_FIFO_ELS];
  logic [ptr_w_lp-1:0] wptr_r, rptr_r;
  logic [count_w_lp-1:0] count_r, count_n;
  logic ready_r;
  logic enq;

  assign enq = req_v_i & ready_r;
  assign req_ready_o = ready_r;
  assign deq_v_o = (count_r != '0);
  assign deq_pkt_o = mem[rptr_r];

  always_comb begin
    case ({enq, deq_yumi_i})
      2'b10: count_n = count_r + 1'b1;
      2'b01: count_n = count_r - 1'b1;
      default: count_n = count_r;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r <= '0;
      rptr_r <= '0;
      count_r <= '0;
      ready_r <= 1'b0;
    end else begin
      count_r <= count_n;
      // registered full flag keeps ready independent of the input valid
      ready_r <= (count_n != `CL_FIFO_ELS);
      if (enq) begin
        wptr_r <= (wptr_r == ptr_w_lp'(`CL_FIFO_ELS - 1)) ? '0 : wptr_r + 1'b1;
      end
      if (deq_yumi_i) begin
        rptr_r <= (rptr_r == ptr_w_lp'(`CL_FIFO_ELS - 1)) ? '0 : rptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem[wptr_r] <= req_pkt_i;
    end
  end

  // adapter must not pop an empty queue
  assert property (@(posedge clk_i) disable iff (reset_i) deq_yumi_i |-> deq_v_o);

endmodule

// ==== hw/cache_link_pkg.sv ====
// shared types for the cache link adapter, referenced by scoped name from every module
`include "cache_link_params.svh"

package cache_link_pkg;

  typedef logic [`CL_LINK_ADDR_WIDTH-1:0] link_addr_t;
  typedef logic [`CL_CACHE_ADDR_WIDTH-1:0] cache_addr_t;
  typedef logic [`CL_DATA_WIDTH-1:0] data_t;
  typedef logic [3:0] mask_t;
  typedef logic [4:0] reg_id_t;
  typedef logic [`CL_X_CORD_WIDTH-1:0] x_cord_t;
  typedef logic [`CL_Y_CORD_WIDTH-1:0] y_cord_t;

  typedef enum logic [2:0] {
    e_remote_store,
    e_remote_sw,
    e_remote_load,
    e_remote_amoadd,
    e_remote_amoswap
  } link_op_e;

  typedef struct packed {
    logic icache_fetch;
    logic is_byte_op;
    logic is_hex_op;
    logic is_unsigned_op;
    logic [1:0] part_sel;
  } load_info_s;

  typedef struct packed {
    link_op_e op;
    link_addr_t addr;
    data_t payload;
    mask_t mask;
    reg_id_t reg_id;
    load_info_s load_info;
    y_cord_t src_y_cord;
    x_cord_t src_x_cord;
  } req_pkt_s;

  typedef enum logic [3:0] {
    e_op_sm,
    e_op_lw,
    e_op_lh,
    e_op_lhu,
    e_op_lb,
    e_op_lbu,
    e_op_amoadd,
    e_op_amoswap,
    e_op_tagst,
    e_op_tagla,
    e_op_tagfl
  } cache_op_e;

  typedef struct packed {
    cache_op_e opcode;
    cache_addr_t addr;
    data_t data;
    mask_t mask;
  } cache_pkt_s;

  typedef enum logic [1:0] {
    e_return_credit,
    e_return_int_wb,
    e_return_ifetch
  } return_type_e;

  typedef struct packed {
    return_type_e pkt_type;
    data_t data;
    reg_id_t reg_id;
    y_cord_t y_cord;
    x_cord_t x_cord;
  } return_pkt_s;

  // what the adapter remembers about each request in flight
  typedef struct packed {
    return_type_e pkt_type;
    reg_id_t reg_id;
    y_cord_t y_cord;
    x_cord_t x_cord;
  } return_info_s;

endpackage

// ==== hw/cache_link_params.svh ====
// widths and cache geometry for the cache link adapter, include wherever a CL_ macro is used
`ifndef CACHE_LINK_PARAMS_SVH
`define CACHE_LINK_PARAMS_SVH

// link side
`define CL_LINK_ADDR_WIDTH 10
`define CL_DATA_WIDTH 32
`define CL_X_CORD_WIDTH 4
`define CL_Y_CORD_WIDTH 3

// cache geometry, tag array holds sets * ways entries
`define CL_SETS 8
`define CL_WAYS 2
`define CL_BLOCK_WORDS 4

// instruction block length in words
`define CL_IFETCH_WORDS 4

`define CL_FIFO_ELS 4

// byte address on the cache side: link word address minus top bit, plus byte bits
`define CL_CACHE_ADDR_WIDTH 11

`endif
